// File: hw/clk_cfg_pkg.sv
// Compute clock frequency request type and synthesizer multiplier and divider tables
`default_nettype none

package clk_cfg_pkg;

   // Number of selectable compute clock settings
   localparam int NUM_FREQ_CODES = 8;

   // Request code as seen on cdc_conf
   typedef logic [2:0] freq_code_t;

   // Output frequency is f_in * FREQ_MUL / FREQ_DIV
   // Entry 0 is the slowest setting, entry 7 the fastest
   localparam logic [7:0] FREQ_MUL [NUM_FREQ_CODES] = '{
      8'd2,    // Quarter speed
      8'd3,
      8'd4,
      8'd5,
      8'd6,
      8'd7,
      8'd8,
      8'd9     // Above nominal
   };

   // The synthesizer is programmed with value minus one
   localparam logic [7:0] FREQ_DIV [NUM_FREQ_CODES] = '{
      8'd8, 8'd8, 8'd6, 8'd6,
      8'd4, 8'd4, 8'd3, 8'd2
   };

endpackage

`default_nettype wire

// File: hw/dcm_prog_pkg.sv
// Synthesizer programming commands, word width and programming word union
`default_nettype none

package dcm_prog_pkg;

   localparam int PROG_WORD_BITS = 10;
   localparam int PROG_VAL_BITS  = PROG_WORD_BITS - 2;

   // Command sits in the two LSBs, sent first on prog_data
   typedef enum logic [1:0] {
      CMD_GO     = 2'b00,   // Apply loaded M and D
      CMD_LOAD_D = 2'b01,
      CMD_LOAD_M = 2'b11
   } prog_cmd_t;

   typedef struct packed {
      logic [PROG_VAL_BITS-1:0] value;   // Table entry minus one
      prog_cmd_t                cmd;
   } prog_fields_t;

   // Producer fills the fields, serializer shifts the raw bits
   typedef union packed {
      logic [PROG_WORD_BITS-1:0] raw;
      prog_fields_t              f;
   } prog_word_u;

endpackage

`default_nettype wire

// File: hw/reset_sequencer.sv
// Lock qualification, system and processor reset stretching, clock enables
`default_nettype none
`timescale 1ns/1ps

module reset_sequencer #(
   parameter int NUM_CT_CLOCKS = 2,
   parameter int RST_WIDTH     = 16
) (
   input  logic                     clk_buffered,
   input  logic                     rst_locked,
   input  logic [NUM_CT_CLOCKS-1:0] ct_locked,
   input  logic                     noc_locked,
   input  logic                     dbg_locked,
   input  logic                     sys_halt,
   input  logic                     cpu_reset,
   input  logic                     cpu_start,
   output logic                     rst_sys,
   output logic                     rst_cpu,
   output logic [NUM_CT_CLOCKS-1:0] clk_en_ct,
   output logic                     clk_en_noc,
   output logic                     clk_en_dbg
);

   localparam int               CNT_W    = $clog2(RST_WIDTH + 1);
   localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(RST_WIDTH - 1);

   logic             all_locked;
   logic             locks_ok;
   logic [CNT_W-1:0] sys_cnt;
   logic [CNT_W-1:0] cpu_cnt;
   logic             cpu_hold;    // Processor parked until cpu_start
   logic             cpu_rst_q;

   assign all_locked = (&ct_locked) & noc_locked & dbg_locked;

   // Any lock loss drops locks_ok on the next edge
   always_ff @(posedge clk_buffered) begin
      if (rst_locked) begin
         locks_ok <= 1'b0;
      end else begin
         locks_ok <= all_locked;
      end
   end

   // System reset released RST_WIDTH cycles after locks_ok rises
   always_ff @(posedge clk_buffered) begin
      if (rst_locked || !locks_ok) begin
         sys_cnt <= CNT_LOAD;
         rst_sys <= 1'b1;
      end else if (sys_cnt != '0) begin
         sys_cnt <= sys_cnt - 1'b1;
      end else begin
         rst_sys <= 1'b0;
      end
   end

   always_ff @(posedge clk_buffered) begin
      if (rst_locked || cpu_reset) begin
         cpu_hold  <= 1'b1;
         cpu_rst_q <= 1'b1;
         cpu_cnt   <= CNT_LOAD;
      end else if (cpu_hold) begin
         cpu_cnt <= CNT_LOAD;
         // Start only counts once the system is out of reset
         if (cpu_start && !rst_sys) begin
            cpu_hold <= 1'b0;
         end
      end else if (cpu_cnt != '0) begin
         cpu_cnt <= cpu_cnt - 1'b1;
      end else begin
         cpu_rst_q <= 1'b0;
      end
   end

   assign rst_cpu = rst_sys | cpu_rst_q;

   // Enables feed the gated global buffers outside
   assign clk_en_ct  = ct_locked & {NUM_CT_CLOCKS{~sys_halt}};
   assign clk_en_noc = noc_locked & ~sys_halt;
   assign clk_en_dbg = dbg_locked;   // Debug keeps running during halt

endmodule

`default_nettype wire

// File: hw/freq_select.sv
// Frequency request latch and three-word programming sequence emitter
`default_nettype none
`timescale 1ns/1ps

module freq_select
   import clk_cfg_pkg::*, dcm_prog_pkg::*;
#(
   parameter int FIFO_DEPTH = 8
) (
   input  logic                            clk_buffered,
   input  logic                            rst_locked,
   input  logic                            cdc_enable,
   input  freq_code_t                      cdc_conf,
   input  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_free,
   output logic                            word_wr,
   output prog_word_u                      word
);

   localparam int FREE_W = $clog2(FIFO_DEPTH + 1);

   logic       pending;
   freq_code_t pend_code;   // Newest requested code
   freq_code_t act_code;    // Code of the sequence in flight
   freq_code_t cur_code;
   logic [1:0] step;        // 0 LOAD_D or idle, 1 LOAD_M, 2 GO
   logic       start;

   // Whole sequence fits, so the three words go out back to back
   assign start = (step == 2'd0) && pending && (fifo_free >= FREE_W'(3));

   always_ff @(posedge clk_buffered) begin
      if (rst_locked) begin
         pending <= 1'b0;
      end else if (cdc_enable) begin
         pending <= 1'b1;   // Overrides a waiting request
      end else if (start) begin
         pending <= 1'b0;
      end
   end

   always_ff @(posedge clk_buffered) begin
      if (cdc_enable) begin
         pend_code <= cdc_conf;
      end
      if (start) begin
         act_code <= pend_code;
      end
   end

   always_ff @(posedge clk_buffered) begin
      if (rst_locked) begin
         step <= 2'd0;
      end else begin
         case (step)
            2'd0:    step <= start ? 2'd1 : 2'd0;
            2'd1:    step <= 2'd2;
            default: step <= 2'd0;
         endcase
      end
   end

   assign cur_code = (step == 2'd0) ? pend_code : act_code;
   assign word_wr  = start || (step != 2'd0);

   always_comb begin
      case (step)
         2'd0: begin
            word.f.value = FREQ_DIV[cur_code] - 8'd1;
            word.f.cmd   = CMD_LOAD_D;
         end
         2'd1: begin
            word.f.value = FREQ_MUL[cur_code] - 8'd1;
            word.f.cmd   = CMD_LOAD_M;
         end
         default: begin
            word.f.value = '0;
            word.f.cmd   = CMD_GO;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: hw/prog_word_fifo.sv
// Circular queue of programming words with empty flag and free-slot count
`default_nettype none
`timescale 1ns/1ps

module prog_word_fifo
   import dcm_prog_pkg::*;
#(
   parameter int FIFO_DEPTH = 8
) (
   input  logic                            clk_buffered,
   input  logic                            rst_locked,
   input  logic                            word_wr,
   input  prog_word_u                      word,
   input  logic                            word_rd,
   output prog_word_u                      head_word,
   output logic                            fifo_empty,
   output logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_free
);

   localparam int               PTR_W   = $clog2(FIFO_DEPTH);
   localparam int               CNT_W   = $clog2(FIFO_DEPTH + 1);
   localparam logic [PTR_W-1:0] PTR_MAX = PTR_W'(FIFO_DEPTH - 1);

   prog_word_u       mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_rd;

   assign do_rd = word_rd && !fifo_empty;

   always_ff @(posedge clk_buffered) begin
      if (rst_locked) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (word_wr) begin
            wr_ptr <= (wr_ptr == PTR_MAX) ? '0 : wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= (rd_ptr == PTR_MAX) ? '0 : rd_ptr + 1'b1;
         end
         if (word_wr && !do_rd) begin
            count <= count + 1'b1;
         end else if (do_rd && !word_wr) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_buffered) begin
      if (word_wr) begin
         mem[wr_ptr] <= word;
      end
   end

   assign head_word  = mem[rd_ptr];
   assign fifo_empty = (count == '0);
   assign fifo_free  = CNT_W'(FIFO_DEPTH) - count;   // Producer back-pressure

endmodule

`default_nettype wire

// File: hw/dcm_prog_serializer.sv
// Bit-serial synthesizer programming FSM with prog_done wait after GO
`default_nettype none
`timescale 1ns/1ps

module dcm_prog_serializer
   import dcm_prog_pkg::*;
(
   input  logic       clk_buffered,
   input  logic       rst_locked,
   input  logic       fifo_empty,
   input  prog_word_u head_word,
   input  logic       prog_done,
   output logic       word_rd,
   output logic       prog_en,
   output logic       prog_data,
   output logic       prog_busy
);

   localparam logic [1:0] ST_IDLE      = 2'd0;
   localparam logic [1:0] ST_SHIFT     = 2'd1;
   localparam logic [1:0] ST_GAP       = 2'd2;
   localparam logic [1:0] ST_WAIT_DONE = 2'd3;

   localparam logic [3:0] LAST_BIT = 4'(PROG_WORD_BITS - 1);

   logic [1:0]                state;
   logic [3:0]                bit_cnt;
   logic [PROG_WORD_BITS-1:0] shreg;
   logic                      is_go;   // Word in flight is a GO command

   assign word_rd = (state == ST_IDLE) && !fifo_empty;

   always_ff @(posedge clk_buffered) begin
      if (rst_locked) begin
         state   <= ST_IDLE;
         bit_cnt <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (word_rd) begin
                  state   <= ST_SHIFT;
                  bit_cnt <= '0;
               end
            end
            ST_SHIFT: begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == LAST_BIT) begin
                  // GO goes straight to waiting with prog_en low
                  state <= is_go ? ST_WAIT_DONE : ST_GAP;
               end
            end
            ST_GAP: state <= ST_IDLE;
            default: begin
               if (prog_done) begin
                  state <= ST_IDLE;
               end
            end
         endcase
      end
   end

   // LSB first out of the raw view
   always_ff @(posedge clk_buffered) begin
      if (word_rd) begin
         shreg <= head_word.raw;
         is_go <= (head_word.f.cmd == CMD_GO);
      end else if (state == ST_SHIFT) begin
         shreg <= shreg >> 1;
      end
   end

   assign prog_en   = (state == ST_SHIFT);
   assign prog_data = prog_en && shreg[0];
   assign prog_busy = (state != ST_IDLE);

endmodule

`default_nettype wire

// File: hw/clk_mgr_top.sv
// Clock manager control top with reset sequencer and synthesizer programming path
`default_nettype none
`timescale 1ns/1ps

module clk_mgr_top
   import clk_cfg_pkg::*, dcm_prog_pkg::*;
#(
   parameter int NUM_CT_CLOCKS = 2,
   parameter int RST_WIDTH     = 16,
   parameter int FIFO_DEPTH    = 8    // At least one full sequence of 3 words
) (
   input  logic                     clk_buffered,
   input  logic                     rst_locked,
   input  logic [NUM_CT_CLOCKS-1:0] ct_locked,
   input  logic                     noc_locked,
   input  logic                     dbg_locked,
   input  logic                     sys_halt,
   input  logic                     cpu_reset,
   input  logic                     cpu_start,
   input  logic                     cdc_enable,
   input  freq_code_t               cdc_conf,
   input  logic                     prog_done,
   output logic                     rst_sys,
   output logic                     rst_cpu,
   output logic [NUM_CT_CLOCKS-1:0] clk_en_ct,
   output logic                     clk_en_noc,
   output logic                     clk_en_dbg,
   output logic                     prog_en,
   output logic                     prog_data,
   output logic                     prog_busy
);

   logic                            word_wr;
   prog_word_u                      word;
   logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_free;
   logic                            fifo_empty;
   prog_word_u                      head_word;
   logic                            word_rd;

   reset_sequencer #(
      .NUM_CT_CLOCKS (NUM_CT_CLOCKS),
      .RST_WIDTH     (RST_WIDTH)
   ) i_reset_sequencer (
      .clk_buffered, .rst_locked, .ct_locked, .noc_locked, .dbg_locked,
      .sys_halt, .cpu_reset, .cpu_start,
      .rst_sys, .rst_cpu, .clk_en_ct, .clk_en_noc, .clk_en_dbg
   );

   freq_select #(.FIFO_DEPTH(FIFO_DEPTH)) i_freq_select (
      .clk_buffered, .rst_locked, .cdc_enable, .cdc_conf, .fifo_free,
      .word_wr, .word
   );

   prog_word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_prog_word_fifo (
      .clk_buffered, .rst_locked, .word_wr, .word, .word_rd,
      .head_word, .fifo_empty, .fifo_free
   );

   // Single programming channel for the compute clock synthesizer
   dcm_prog_serializer i_dcm_prog_serializer (
      .clk_buffered, .rst_locked, .fifo_empty, .head_word, .prog_done,
      .word_rd, .prog_en, .prog_data, .prog_busy
   );

endmodule

`default_nettype wire

// File: verif/clk_mgr_props.sv
// Bound concurrent assertions on reset sequencing and clock enable gating of the clock manager top
`default_nettype none
`timescale 1ns/1ps

module clk_mgr_props #(
   parameter int NUM_CT_CLOCKS = 2,
   parameter int RST_WIDTH     = 16
) (
   input logic                     clk_buffered,
   input logic                     rst_locked,
   input logic [NUM_CT_CLOCKS-1:0] ct_locked,
   input logic                     noc_locked,
   input logic                     dbg_locked,
   input logic                     sys_halt,
   input logic                     cpu_reset,
   input logic                     cpu_start,
   input logic                     rst_sys,
   input logic                     rst_cpu,
   input logic [NUM_CT_CLOCKS-1:0] clk_en_ct,
   input logic                     clk_en_noc,
   input logic                     clk_en_dbg
);

   logic all_locked;
   int   fail_cnt = 0;   // Summed into the final count

   assign all_locked = (&ct_locked) && noc_locked && dbg_locked;

   // Lock loss seen at one edge shows up as rst_sys two samples later
   lock_loss_raises_rst: assert property (@(posedge clk_buffered) disable iff (rst_locked)
      !$past(all_locked, 2) |-> rst_sys)
      else begin
         $error("rst_sys low two cycles after a lock loss");
         fail_cnt++;
      end

   // Release only after RST_WIDTH + 1 samples of steady lock
   sys_release_time: assert property (@(posedge clk_buffered) disable iff (rst_locked)
      $fell(rst_sys) |-> $past(all_locked, RST_WIDTH + 1) && !$past(all_locked, RST_WIDTH + 2))
      else begin
         $error("rst_sys released at the wrong time after lock");
         fail_cnt++;
      end

   cpu_release_time: assert property (@(posedge clk_buffered) disable iff (rst_locked)
      $fell(rst_cpu) && !$past(rst_sys) |-> $past(cpu_start, RST_WIDTH + 1))
      else begin
         $error("rst_cpu released at the wrong time after cpu_start");
         fail_cnt++;
      end

   cpu_reset_next: assert property (@(posedge clk_buffered) disable iff (rst_locked)
      cpu_reset |=> rst_cpu)
      else begin
         $error("rst_cpu not raised after cpu_reset");
         fail_cnt++;
      end

   ct_enable_rule: assert property (@(posedge clk_buffered)
      clk_en_ct == (ct_locked & {NUM_CT_CLOCKS{!sys_halt}}))
      else begin
         $error("clk_en_ct does not follow lock and halt");
         fail_cnt++;
      end

   noc_enable_rule: assert property (@(posedge clk_buffered)
      clk_en_noc == (noc_locked && !sys_halt))
      else begin
         $error("clk_en_noc does not follow lock and halt");
         fail_cnt++;
      end

   dbg_enable_rule: assert property (@(posedge clk_buffered) clk_en_dbg == dbg_locked)
      else begin
         $error("clk_en_dbg does not follow its lock");
         fail_cnt++;
      end

endmodule

bind clk_mgr_top clk_mgr_props #(
   .NUM_CT_CLOCKS (NUM_CT_CLOCKS),
   .RST_WIDTH     (RST_WIDTH)
) i_clk_mgr_props (
   .clk_buffered, .rst_locked, .ct_locked, .noc_locked, .dbg_locked,
   .sys_halt, .cpu_reset, .cpu_start,
   .rst_sys, .rst_cpu, .clk_en_ct, .clk_en_noc, .clk_en_dbg
);

`default_nettype wire

// File: verif/clk_mgr_tb.sv
// Clock manager testbench with clock, reset, stimulus, serial word capture, checks and timeout
`default_nettype none
`timescale 1ns/1ps

module clk_mgr_tb
   import clk_cfg_pkg::*;
();

   localparam int          NUM_CT    = 2;
   localparam int          RST_WIDTH = 16;
   localparam int          NUM_TESTS = 5;
   localparam logic [31:0] LFSR_TAPS = 32'h80200003;

   // Cycle budget of each test
   localparam int LEN_RESET    = 4;
   localparam int LEN_POWER_UP = 70;
   localparam int LEN_CPU      = 60;
   localparam int LEN_ENABLES  = 50;
   localparam int LEN_SINGLE   = 50;
   localparam int LEN_B2B      = 100;
   localparam int TIMEOUT_CYCLES =
      (LEN_RESET + LEN_POWER_UP + LEN_CPU + LEN_ENABLES + LEN_SINGLE + LEN_B2B) * 5 / 4;

   logic              clk_buffered = 1'b0;
   logic              rst_locked;
   logic [NUM_CT-1:0] ct_locked;
   logic              noc_locked;
   logic              dbg_locked;
   logic              sys_halt;
   logic              cpu_reset;
   logic              cpu_start;
   logic              cdc_enable;
   freq_code_t        cdc_conf;
   logic              prog_done;
   logic              rst_sys;
   logic              rst_cpu;
   logic [NUM_CT-1:0] clk_en_ct;
   logic              clk_en_noc;
   logic              clk_en_dbg;
   logic              prog_en;
   logic              prog_data;
   logic              prog_busy;

   logic [31:0] lfsr_state    = 32'ha0ea743e;
   string       test_name     = "reset";
   int          errors        = 0;
   int          checks        = 0;
   int          err_mark      = 0;
   int          cycle_cnt     = 0;
   logic [9:0]  exp_q [$];              // Words still due on prog_data
   logic [9:0]  exp_word;
   logic [9:0]  cap_word      = '0;
   int          cap_bits      = 0;
   int          serial_errors = 0;
   int          serial_checks = 0;
   logic        go_wait       = 1'b0;   // GO sent, next word needs prog_done first
   logic        done_seen     = 1'b0;

   always #2 clk_buffered = ~clk_buffered;

   clk_mgr_top #(
      .NUM_CT_CLOCKS (NUM_CT),
      .RST_WIDTH     (RST_WIDTH),
      .FIFO_DEPTH    (8)
   ) i_clk_mgr_top (
      .clk_buffered, .rst_locked, .ct_locked, .noc_locked, .dbg_locked,
      .sys_halt, .cpu_reset, .cpu_start, .cdc_enable, .cdc_conf, .prog_done,
      .rst_sys, .rst_cpu, .clk_en_ct, .clk_en_noc, .clk_en_dbg,
      .prog_en, .prog_data, .prog_busy
   );

   function automatic logic [7:0] random_bits(input int count);
      logic [7:0] val;
      val = '0;
      for (int i = 0; i < count; i++) begin
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
         val = {val[6:0], lfsr_state[0]};
      end
      return val;
   endfunction

   function automatic int error_total();
      return errors + serial_errors + i_clk_mgr_top.i_clk_mgr_props.fail_cnt;
   endfunction

   task automatic next_cycle();
      @(posedge clk_buffered);
      #1;   // Inputs change away from the edge
   endtask

   task automatic expect_equal(input string what, input int exp, input int act);
      checks++;
      assert (act == exp) else begin
         $display("** Error [%s] %s: expected %0d, actual %0d", test_name, what, exp, act);
         errors++;
      end
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      err_mark  = error_total();
   endtask

   task automatic end_test();
      $display("%-22s done, %0d errors", test_name, error_total() - err_mark);
   endtask

   task automatic wait_sys_release();
      while (rst_sys) next_cycle();
   endtask

   // Counted from the cycle in which cpu_start is driven
   task automatic release_cpu();
      int n;
      n = 0;
      cpu_start = 1'b1;
      do begin
         next_cycle();
         cpu_start = 1'b0;
         n++;
      end while (rst_cpu);
      expect_equal("rst_cpu release cycles", RST_WIDTH + 1, n);
   endtask

   task automatic queue_sequence(input freq_code_t code);
      exp_q.push_back({FREQ_DIV[code] - 8'd1, 2'b01});
      exp_q.push_back({FREQ_MUL[code] - 8'd1, 2'b11});
      exp_q.push_back(10'b00_0000_0000);   // GO
   endtask

   task automatic power_up_reset();
      int n;
      begin_test("power_up_reset");
      repeat (20) begin
         next_cycle();
         expect_equal("rst_sys while unlocked", 1, int'(rst_sys));
      end
      ct_locked = '1;
      n = 0;
      do begin
         next_cycle();
         n++;
      end while (rst_sys);
      expect_equal("rst_sys release cycles", RST_WIDTH + 1, n);
      noc_locked = 1'b0;
      repeat (2) next_cycle();
      expect_equal("rst_sys after noc lock loss", 1, int'(rst_sys));
      noc_locked = 1'b1;
      wait_sys_release();
      end_test();
   endtask

   task automatic cpu_hold_restart();
      begin_test("cpu_hold_restart");
      repeat (4) begin
         next_cycle();
         expect_equal("rst_cpu before cpu_start", 1, int'(rst_cpu));
      end
      release_cpu();
      cpu_reset = 1'b1;
      next_cycle();
      cpu_reset = 1'b0;
      expect_equal("rst_cpu after cpu_reset", 1, int'(rst_cpu));
      repeat (4) begin
         next_cycle();
         expect_equal("rst_cpu held after cpu_reset", 1, int'(rst_cpu));
      end
      release_cpu();
      end_test();
   endtask

   task automatic clock_enables();
      logic [7:0]        r;
      logic [NUM_CT-1:0] exp_ct;
      begin_test("clock_enables");
      repeat (24) begin
         r          = random_bits(NUM_CT + 3);
         ct_locked  = r[NUM_CT-1:0];
         noc_locked = r[NUM_CT];
         dbg_locked = r[NUM_CT+1];
         sys_halt   = r[NUM_CT+2];
         exp_ct     = sys_halt ? '0 : ct_locked;
         #1;
         expect_equal("clk_en_ct", int'(exp_ct), int'(clk_en_ct));
         expect_equal("clk_en_noc", int'(noc_locked && !sys_halt), int'(clk_en_noc));
         expect_equal("clk_en_dbg", int'(dbg_locked), int'(clk_en_dbg));
         next_cycle();
      end
      ct_locked  = '1;
      noc_locked = 1'b1;
      dbg_locked = 1'b1;
      sys_halt   = 1'b0;
      next_cycle();
      wait_sys_release();
      end_test();
   endtask

   task automatic send_request(input freq_code_t code);
      cdc_conf   = code;
      cdc_enable = 1'b1;
      next_cycle();
      cdc_enable = 1'b0;
   endtask

   task automatic single_request();
      logic [7:0] r;
      begin_test("single_request");
      prog_done = 1'b1;   // Synthesizer answers at once
      r = random_bits(3);
      queue_sequence(r[2:0]);
      send_request(r[2:0]);
      while (exp_q.size() != 0 || prog_busy) next_cycle();
      end_test();
   endtask

   task automatic back_to_back_requests();
      logic [7:0] first_r;
      logic [7:0] merged_r;
      logic [7:0] last_r;
      begin_test("back_to_back_requests");
      prog_done = 1'b0;
      first_r   = random_bits(3);
      merged_r  = random_bits(3);
      last_r    = random_bits(3);
      // Middle code is overwritten before the producer takes it
      queue_sequence(first_r[2:0]);
      queue_sequence(last_r[2:0]);
      cdc_conf   = first_r[2:0];
      cdc_enable = 1'b1;
      next_cycle();
      cdc_conf = merged_r[2:0];
      next_cycle();
      cdc_conf = last_r[2:0];
      next_cycle();
      cdc_enable = 1'b0;
      while (exp_q.size() > 3) next_cycle();
      repeat (8) begin
         next_cycle();
         expect_equal("prog_en while waiting for prog_done", 0, int'(prog_en));
         expect_equal("prog_busy while waiting for prog_done", 1, int'(prog_busy));
      end
      prog_done = 1'b1;
      while (exp_q.size() != 0 || prog_busy) next_cycle();
      prog_done = 1'b0;
      end_test();
   endtask

   // Serial capture at the falling edge, away from every input change
   always @(negedge clk_buffered) begin
      if (prog_en) begin
         serial_checks++;
         assert (!go_wait || done_seen) else begin
            $display("[%s] prog_en went high after GO before prog_done", test_name);
            serial_errors++;
         end
         go_wait  = 1'b0;
         cap_word = {prog_data, cap_word[9:1]};   // LSB arrives first
         cap_bits++;
      end else if (cap_bits != 0) begin
         serial_checks++;
         assert (cap_bits == 10) else begin
            $display("** Error [%s] prog_en high cycles: expected 10, actual %0d",
                     test_name, cap_bits);
            serial_errors++;
         end
         assert (exp_q.size() != 0) else begin
            $display("[%s] serial word %h sent when none was due", test_name, cap_word);
            serial_errors++;
         end
         if (exp_q.size() != 0) begin
            exp_word = exp_q.pop_front();
            assert (cap_word == exp_word) else begin
               $display("** Error [%s] serial word: expected %h, actual %h",
                        test_name, exp_word, cap_word);
               serial_errors++;
            end
         end
         go_wait   = (cap_word[1:0] == 2'b00);
         done_seen = 1'b0;
         cap_bits  = 0;
      end
      if (prog_done) begin
         done_seen = 1'b1;
      end
   end

   always @(posedge clk_buffered) begin
      cycle_cnt++;
      if (cycle_cnt > TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles in %s, the DUT stopped responding",
                  cycle_cnt, test_name);
         $display("Test failed");
         $finish;
      end
   end

   initial begin
      rst_locked = 1'b1;
      ct_locked  = '0;
      noc_locked = 1'b1;
      dbg_locked = 1'b1;
      sys_halt   = 1'b0;
      cpu_reset  = 1'b0;
      cpu_start  = 1'b0;
      cdc_enable = 1'b0;
      cdc_conf   = '0;
      prog_done  = 1'b0;
      repeat (LEN_RESET) @(posedge clk_buffered);
      #1;
      rst_locked = 1'b0;
      power_up_reset();
      cpu_hold_restart();
      clock_enables();
      single_request();
      back_to_back_requests();
      $display("Tests run: %0d, checks: %0d, errors: %0d",
               NUM_TESTS, checks + serial_checks, error_total());
      if (error_total() == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
hw/clk_cfg_pkg.sv
hw/dcm_prog_pkg.sv
hw/reset_sequencer.sv
hw/freq_select.sv
hw/prog_word_fifo.sv
hw/dcm_prog_serializer.sv
hw/clk_mgr_top.sv
verif/clk_mgr_props.sv
verif/clk_mgr_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module clk_mgr_tb -Mdir obj_dir -f src.f
	./obj_dir/Vclk_mgr_tb +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
